// ==== verilog/vga_params.svh ====
`ifndef VGA_PARAMS_SVH
`define VGA_PARAMS_SVH

// visible raster, kept small so whole frames simulate quickly
// 1024x768 timing values drop in here unchanged
`define VGA_WIDTH        16
`define VGA_HEIGHT       8

// horizontal region lengths in pixel clocks
`define VGA_H_FRONT      2
`define VGA_H_SYNC       3
`define VGA_H_BACK       2

// vertical region lengths in lines
`define VGA_V_FRONT      1
`define VGA_V_SYNC       2
`define VGA_V_BACK       1

// bits per colour channel
`define VGA_COLOR_DEPTH  8

// a line runs front porch, sync, back porch, then the visible pixels
`define VGA_H_TOTAL      (`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK + `VGA_WIDTH)

// a frame is ordered the same way, counted in lines
`define VGA_V_TOTAL      (`VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK + `VGA_HEIGHT)

`endif

// ==== verilog/vga_pkg.sv ====
`default_nettype none

`include "vga_params.svh"

package vga_pkg;

    // one pixel as it leaves the chip, red in the top bits
    typedef struct packed {
        logic [`VGA_COLOR_DEPTH-1:0] r;
        logic [`VGA_COLOR_DEPTH-1:0] g;
        logic [`VGA_COLOR_DEPTH-1:0] b;
    } pixel_t;

    // column index inside the visible area
    typedef logic [$clog2(`VGA_WIDTH)-1:0] hpos_t;

    // row index inside the visible area
    typedef logic [$clog2(`VGA_HEIGHT)-1:0] vpos_t;

    // test patterns selectable through the configuration port
    typedef enum logic [1:0] {
        pat_bars     = 2'd0,
        pat_checker  = 2'd1,
        pat_gradient = 2'd2
    } pattern_e;

endpackage

`default_nettype wire

// ==== verilog/vga_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vga_params.svh"

module vga_timing
    import vga_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    output logic  frame_start,
    output logic  active,
    output logic  h_sync,
    output logic  v_sync,
    output hpos_t x,
    output vpos_t y
);

    localparam int HW = $clog2(`VGA_H_TOTAL);
    localparam int VW = $clog2(`VGA_V_TOTAL);

    // region boundaries along a line
    localparam logic [HW-1:0] H_SYNC_START = HW'(`VGA_H_FRONT);
    localparam logic [HW-1:0] H_BACK_START = HW'(`VGA_H_FRONT + `VGA_H_SYNC);
    localparam logic [HW-1:0] H_ADDR_START = HW'(`VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK);
    localparam logic [HW-1:0] H_LAST       = HW'(`VGA_H_TOTAL - 1);

    // region boundaries down a frame
    localparam logic [VW-1:0] V_SYNC_START = VW'(`VGA_V_FRONT);
    localparam logic [VW-1:0] V_BACK_START = VW'(`VGA_V_FRONT + `VGA_V_SYNC);
    localparam logic [VW-1:0] V_ADDR_START = VW'(`VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK);
    localparam logic [VW-1:0] V_LAST       = VW'(`VGA_V_TOTAL - 1);

    logic [HW-1:0] h_cnt;
    logic [VW-1:0] v_cnt;
    logic [HW-1:0] h_nxt;
    logic [VW-1:0] v_nxt;
    logic          h_sync_nxt;
    logic          v_sync_nxt;
    logic          h_addr_nxt;
    logic          v_addr_nxt;

    // the flags are decoded from the next count so that they are
    // registered in the same cycle as the counters they describe
    always_comb begin
        h_nxt = (h_cnt == H_LAST) ? '0 : h_cnt + 1'b1;
        v_nxt = v_cnt;
        if (h_cnt == H_LAST) begin
            v_nxt = (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end

        h_sync_nxt = (h_nxt >= H_SYNC_START) && (h_nxt < H_BACK_START);
        v_sync_nxt = (v_nxt >= V_SYNC_START) && (v_nxt < V_BACK_START);
        h_addr_nxt = (h_nxt >= H_ADDR_START);
        v_addr_nxt = (v_nxt >= V_ADDR_START);
    end

    // reset parks both counters at zero, the first front porch cycle,
    // so frame_start is already high for that state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            frame_start <= 1'b1;
            active      <= 1'b0;
            h_sync      <= 1'b0;
            v_sync      <= 1'b0;
        end else begin
            h_cnt       <= h_nxt;
            v_cnt       <= v_nxt;
            frame_start <= (h_nxt == '0) && (v_nxt == '0);
            active      <= h_addr_nxt && v_addr_nxt;
            h_sync      <= h_sync_nxt;
            v_sync      <= v_sync_nxt;
        end
    end

    // visible coordinates only mean something while active is high
    always_ff @(posedge clk) begin
        x <= hpos_t'(h_nxt - H_ADDR_START);
        y <= vpos_t'(v_nxt - V_ADDR_START);
    end

endmodule

`default_nettype wire

// ==== verilog/pattern_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vga_params.svh"

module pattern_gen
    import vga_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_valid,
    input  pattern_e cfg_pattern,
    input  logic     frame_start,
    input  logic     active,
    input  hpos_t    x,
    input  vpos_t    y,
    output logic     cfg_ready,
    output pixel_t   pixel
);

    localparam int XW = $bits(hpos_t) + 3;
    localparam int CD = `VGA_COLOR_DEPTH;

    localparam logic [XW-1:0]   WIDTH_L = XW'(`VGA_WIDTH);
    localparam logic [CD-1:0]   FULL    = {CD{1'b1}};

    pattern_e      pend_pat;
    logic          pend_valid;
    pattern_e      cur_pat;
    logic [XW-1:0] bar_scaled;
    logic [XW-1:0] bar_idx;
    pixel_t        colour;

    // one choice can wait at a time
    assign cfg_ready = !pend_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
            cur_pat    <= pat_bars;
        end else if (frame_start && pend_valid) begin
            // new pattern takes over only at a frame boundary
            cur_pat    <= pend_pat;
            pend_valid <= 1'b0;
        end else if (cfg_valid && cfg_ready) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_valid && cfg_ready) begin
            pend_pat <= cfg_pattern;
        end
    end

    // eight equal bars, bar index = x * 8 / width
    assign bar_scaled = {x, 3'b000};
    assign bar_idx    = bar_scaled / WIDTH_L;

    always_comb begin
        colour = '0;
        case (cur_pat)
            pat_bars: begin
                colour.r = bar_idx[2] ? FULL : '0;
                colour.g = bar_idx[1] ? FULL : '0;
                colour.b = bar_idx[0] ? FULL : '0;
            end
            pat_checker: begin
                if (x[1] ^ y[1]) begin
                    colour = '1;
                end
            end
            pat_gradient: begin
                colour.r = CD'({x, 4'b0000});
                colour.g = CD'({y, 5'b00000});
            end
            default: colour = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        pixel <= active ? colour : '0;
    end

endmodule

`default_nettype wire

// ==== verilog/vga_output.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_output
    import vga_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   active,
    input  logic   h_sync,
    input  logic   v_sync,
    input  pixel_t pixel,
    output pixel_t vga_rgb,
    output logic   vga_hs,
    output logic   vga_vs,
    output logic   vga_blank_n,
    output logic   vga_sync_n
);

    logic active_d;
    logic h_sync_d;
    logic v_sync_d;

    // the pixel register in the pattern stage costs one cycle,
    // so the flags wait one cycle here to stay beside their colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_d <= 1'b0;
            h_sync_d <= 1'b0;
            v_sync_d <= 1'b0;
        end else begin
            active_d <= active;
            h_sync_d <= h_sync;
            v_sync_d <= v_sync;
        end
    end

    // pin register, colour is black wherever the raster is blanked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_rgb     <= '0;
            vga_hs      <= 1'b0;
            vga_vs      <= 1'b0;
            vga_blank_n <= 1'b0;
            vga_sync_n  <= 1'b1;
        end else begin
            vga_rgb     <= active_d ? pixel : '0;
            vga_hs      <= h_sync_d;
            vga_vs      <= v_sync_d;
            vga_blank_n <= active_d;
            vga_sync_n  <= h_sync_d ~^ v_sync_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/vga_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module vga_top
    import vga_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cfg_valid,
    input  pattern_e cfg_pattern,
    output logic     cfg_ready,
    output pixel_t   vga_rgb,
    output logic     vga_hs,
    output logic     vga_vs,
    output logic     vga_blank_n,
    output logic     vga_sync_n
);

    logic   frame_start;
    logic   active;
    logic   h_sync;
    logic   v_sync;
    hpos_t  x;
    vpos_t  y;
    pixel_t pixel;

    // raster counters and region flags
    vga_timing u_timing (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .active      (active),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .x           (x),
        .y           (y)
    );

    // pattern select and per-pixel colour, one cycle behind the counters
    pattern_gen u_pattern (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_pattern (cfg_pattern),
        .frame_start (frame_start),
        .active      (active),
        .x           (x),
        .y           (y),
        .cfg_ready   (cfg_ready),
        .pixel       (pixel)
    );

    // realign flags with colour and register the pins
    vga_output u_output (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .h_sync      (h_sync),
        .v_sync      (v_sync),
        .pixel       (pixel),
        .vga_rgb     (vga_rgb),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_blank_n (vga_blank_n),
        .vga_sync_n  (vga_sync_n)
    );

endmodule

`default_nettype wire

// ==== bench/vga_top_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vga_params.svh"

module vga_top_chk
    import vga_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input pixel_t vga_rgb,
    input logic   vga_hs,
    input logic   vga_vs,
    input logic   vga_blank_n,
    input logic   vga_sync_n
);

    int hs_run;

    // number of assertion failures so far
    int fail_count = 0;

    // length of the current hs high run
    always_ff @(posedge clk) begin
        hs_run <= vga_hs ? hs_run + 1 : 0;
    end

    // composite sync is high whenever both syncs agree
    a_sync_n: assert property (@(posedge clk) disable iff (!rst_n)
        vga_sync_n == (vga_hs ~^ vga_vs))
        else begin
            fail_count++;
            $error("vga_sync_n differs from the xnor of hs and vs");
        end

    a_blank: assert property (@(posedge clk) disable iff (!rst_n)
        !vga_blank_n |-> vga_rgb == '0)
        else begin
            fail_count++;
            $error("colour is not black while blanked");
        end

    a_hs_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(vga_hs) |-> ##`VGA_H_SYNC !vga_hs)
        else begin
            fail_count++;
            $error("hs pulse did not end after the sync width");
        end

    a_hs_width: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(vga_hs) |-> hs_run == `VGA_H_SYNC)
        else begin
            fail_count++;
            $error("hs pulse has the wrong width");
        end

endmodule

`default_nettype wire

// ==== bench/vga_top_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "vga_params.svh"

module vga_top_tb
    import vga_pkg::*;
();

    localparam int W     = `VGA_WIDTH;
    localparam int H     = `VGA_HEIGHT;
    localparam int CD    = `VGA_COLOR_DEPTH;
    localparam int FRAME = `VGA_H_TOTAL * `VGA_V_TOTAL;
    localparam int TMO   = 3 * FRAME;

    logic     clk;
    logic     rst_n;
    logic     cfg_valid;
    pattern_e cfg_pattern;
    logic     cfg_ready;
    pixel_t   vga_rgb;
    logic     vga_hs;
    logic     vga_vs;
    logic     vga_blank_n;
    logic     vga_sync_n;
    pixel_t   frame_px [H][W];
    int       errors;
    int       tests_run;
    int       tests_failed;
    int       mark;
    int       assert_mark;

    vga_top dut (.*);

    bind vga_top vga_top_chk u_chk (.clk(clk), .rst_n(rst_n), .vga_rgb(vga_rgb),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n), .vga_sync_n(vga_sync_n));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timed out at %0t ns waiting for %s", $time, what);
    endtask

    task automatic compare_pixel(input pixel_t got, input pixel_t exp, input int x, input int y);
        if (got !== exp) begin
            report_error($sformatf("pixel (%0d,%0d) is %h, expected %h", x, y, got, exp));
        end
    endtask

    task automatic compare_pattern(input pattern_e seen, input pattern_e want);
        if (seen !== want) begin
            report_error($sformatf("frame shows %s, expected %s", seen.name(), want.name()));
        end
    endtask

    // colour that each pattern rule gives a visible position
    function automatic pixel_t expected_pixel(input pattern_e p, input int x, input int y);
        pixel_t px;
        int     bar;
        px  = '0;
        bar = x * 8 / W;
        if (p == pat_bars) begin
            px.r = {CD{bar[2]}};
            px.g = {CD{bar[1]}};
            px.b = {CD{bar[0]}};
        end else if (p == pat_checker) begin
            if (((x ^ y) & 2) != 0) begin
                px = '1;
            end
        end else if (p == pat_gradient) begin
            px.r = CD'(x * 16);
            px.g = CD'(y * 32);
        end
        return px;
    endfunction

    // first pattern whose rule fits every recorded pixel, 3 if none does
    function automatic pattern_e classify_frame();
        pattern_e cand;
        logic     fits;
        int       k;
        int       i;
        int       j;
        for (k = 0; k < 3; k++) begin
            cand = pattern_e'(k);
            fits = 1'b1;
            for (i = 0; i < H; i++) begin
                for (j = 0; j < W; j++) begin
                    fits &= (frame_px[i][j] === expected_pixel(cand, j, i));
                end
            end
            if (fits) begin
                return cand;
            end
        end
        return pattern_e'(2'd3);
    endfunction

    task automatic wait_vs_rise();
        int   cyc;
        logic prev;
        prev = 1'b1;
        for (cyc = 0; cyc < TMO && !(vga_vs && !prev); cyc++) begin
            prev = vga_vs;
            @(negedge clk);
        end
        if (!(vga_vs && !prev)) begin
            report_timeout("vga_vs to rise");
        end
    endtask

    // record one frame at the pins, coordinates come from the blank_n runs
    task automatic scan_frame(input pattern_e want);
        int row;
        int col;
        int cyc;
        row = 0;
        col = 0;
        wait_vs_rise();
        for (cyc = 0; cyc < FRAME && row < H; cyc++) begin
            @(negedge clk);
            if (vga_sync_n !== (vga_hs ~^ vga_vs)) begin
                report_error("vga_sync_n is not the xnor of hs and vs");
            end
            if (vga_blank_n) begin
                if (col < W) begin
                    frame_px[row][col] = vga_rgb;
                end
                col++;
            end else begin
                if (vga_rgb !== '0) begin
                    report_error("colour is not black while blanked");
                end
                if (col != 0) begin
                    if (col != W) begin
                        report_error($sformatf("visible run of %0d pixels", col));
                    end
                    row++;
                    col = 0;
                end
            end
        end
        if (row != H) begin
            report_error($sformatf("frame has %0d visible lines", row));
        end
        for (row = 0; row < H; row++) begin
            for (col = 0; col < W; col++) begin
                compare_pixel(frame_px[row][col], expected_pixel(want, col, row), col, row);
            end
        end
        compare_pattern(classify_frame(), want);
    endtask

    function automatic logic sync_level(input logic use_vs);
        return use_vs ? vga_vs : vga_hs;
    endfunction

    // width and repeat period of the next pulse on hs or vs
    task automatic measure_pulse(input logic use_vs, output int high, output int period);
        logic s;
        logic prev;
        high   = 1;
        period = 1;
        wait_vs_rise_or_hs(use_vs);
        s = sync_level(use_vs);
        prev = s;
        @(negedge clk);
        s = sync_level(use_vs);
        while (!(s && !prev) && period < TMO) begin
            if (s) begin
                high++;
            end
            period++;
            prev = s;
            @(negedge clk);
            s = sync_level(use_vs);
        end
        if (!(s && !prev)) begin
            report_timeout("the next sync pulse");
        end
    endtask

    task automatic wait_vs_rise_or_hs(input logic use_vs);
        int   cyc;
        logic prev;
        prev = 1'b1;
        for (cyc = 0; cyc < TMO && !(sync_level(use_vs) && !prev); cyc++) begin
            prev = sync_level(use_vs);
            @(negedge clk);
        end
        if (!(sync_level(use_vs) && !prev)) begin
            report_timeout("a sync pulse to start");
        end
    endtask

    // a pending choice clears on the frame start, which sits at the pins
    // between the last visible pixel and the first blanked cycle
    task automatic wait_ready();
        int   cyc;
        logic waited;
        waited = !cfg_ready;
        for (cyc = 0; cyc < TMO && !cfg_ready; cyc++) begin
            @(negedge clk);
        end
        if (!cfg_ready) begin
            report_timeout("cfg_ready to return");
            return;
        end
        if (waited && !vga_blank_n) begin
            report_error("cfg_ready returned before the last visible pixel");
        end
        @(negedge clk);
        if (waited && vga_blank_n) begin
            report_error("cfg_ready returned after the frame start");
        end
    endtask

    task automatic configure(input pattern_e p);
        @(negedge clk);
        cfg_valid   = 1'b1;
        cfg_pattern = p;
        wait_ready();
        cfg_valid = 1'b0;
        if (cfg_ready !== 1'b0) begin
            report_error("cfg_ready stayed high after a transfer");
        end
    endtask

    task automatic test_reset();
        if (vga_hs || vga_vs || vga_blank_n || vga_rgb !== '0 || !cfg_ready) begin
            report_error("pins or cfg_ready wrong during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (vga_hs || vga_vs || vga_blank_n || vga_rgb !== '0 || !cfg_ready) begin
            report_error("pins or cfg_ready wrong after reset");
        end
        scan_frame(pat_bars);
    endtask

    task automatic test_periods();
        int high;
        int period;
        measure_pulse(1'b0, high, period);
        if (high != `VGA_H_SYNC || period != `VGA_H_TOTAL) begin
            report_error($sformatf("hs high %0d of period %0d", high, period));
        end
        measure_pulse(1'b1, high, period);
        if (high != `VGA_V_SYNC * `VGA_H_TOTAL || period != FRAME) begin
            report_error($sformatf("vs high %0d of period %0d", high, period));
        end
    endtask

    task automatic test_pattern(input pattern_e p);
        repeat ($urandom_range(4 * `VGA_H_TOTAL)) @(negedge clk);
        configure(p);
        wait_ready();
        scan_frame(p);
    endtask

    task automatic test_mid_frame();
        fork
            scan_frame(pat_gradient);
            begin
                wait_vs_rise();
                // lands within visible lines 2 to 4 of the frame being scanned
                repeat ((`VGA_V_SYNC + `VGA_V_BACK + 2) * `VGA_H_TOTAL
                        + $urandom_range(2 * `VGA_H_TOTAL)) @(negedge clk);
                configure(pat_checker);
                // offered while the first choice still waits for its frame
                configure(pat_bars);
            end
        join
        scan_frame(pat_checker);
        wait_ready();
        scan_frame(pat_bars);
    endtask

    task automatic finish_test(input string name, input int start);
        errors += dut.u_chk.fail_count - assert_mark;
        assert_mark = dut.u_chk.fail_count;
        tests_run++;
        if (errors != start) begin
            tests_failed++;
            $display("%s: failed, %0d errors", name, errors - start);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    initial begin
        void'($urandom(51));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        assert_mark  = 0;
        rst_n        = 1'b0;
        cfg_valid    = 1'b0;
        cfg_pattern  = pat_bars;
        repeat (16) @(negedge clk);
        mark = errors;
        test_reset();
        finish_test("reset and first frame", mark);
        mark = errors;
        test_periods();
        finish_test("sync periods", mark);
        mark = errors;
        test_pattern(pat_checker);
        finish_test("checkerboard frame", mark);
        mark = errors;
        test_pattern(pat_gradient);
        finish_test("gradient frame", mark);
        mark = errors;
        test_mid_frame();
        finish_test("mid-frame change", mark);
        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vga_top.f ====
+incdir+verilog
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/pattern_gen.sv
verilog/vga_output.sv
verilog/vga_top.sv
bench/vga_top_chk.sv
bench/vga_top_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= vga_top_tb
FILELIST  ?= vga_top.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx ">>> PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
